// File: design/graph_defs.svh
// Path counter widths and depths

`ifndef GRAPH_DEFS_SVH
`define GRAPH_DEFS_SVH

// Node index width, wide enough for graphs of up to 1024 nodes
`define NODE_IDX_WIDTH 10

// Path count width
`define ACCUM_WIDTH 24

// Remaining-edge counter from the edge source
`define COUNTER_WIDTH 5

// Node queue entries, kept a power of two
`define QUEUE_DEPTH 128

`endif

// File: design/graph_pkg.sv
// Path counter shared types

`include "graph_defs.svh"

package graph_pkg;

    // Node index as seen on the edge port and in the queue
    typedef logic [`NODE_IDX_WIDTH-1:0] node_idx_t;

    // Number of paths reaching a node
    typedef logic [`ACCUM_WIDTH-1:0] count_t;

    // Edges left for the current node, including the one presented
    typedef logic [`COUNTER_WIDTH-1:0] edge_cnt_t;

    // Queue slot pointer
    typedef logic [$clog2(`QUEUE_DEPTH)-1:0] queue_ptr_t;

    // Sequencer states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        SEED  = 3'd1,
        POP   = 3'd2,
        FETCH = 3'd3,
        DONE  = 3'd4
    } ctrl_state_t;

endpackage

// File: design/queue_if.sv
// Node queue operation interface
`timescale 1ns/1ps

interface queue_if;

    // Requests from the sequencer
    logic                 seed;
    logic                 offer;
    graph_pkg::node_idx_t offer_idx;
    logic                 pop;

    // Count carried by an offered edge
    graph_pkg::count_t    offer_val;

    // Queue status and head entry
    logic                 accept;
    graph_pkg::node_idx_t head_idx;
    graph_pkg::count_t    head_val;
    logic                 empty;

    modport ctrl (
        output seed, offer, offer_idx, pop,
        input  accept, head_idx, empty
    );

    modport queue (
        input  seed, offer, offer_idx, pop, offer_val,
        output accept, head_idx, head_val, empty
    );

    modport accum (
        output offer_val,
        input  head_val
    );

endinterface

// File: design/path_ctrl.sv
// Path counter sequencer
`timescale 1ns/1ps

module path_ctrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  graph_pkg::node_idx_t start_idx,
    input  graph_pkg::node_idx_t end_idx,
    input  logic                 edge_valid,
    input  graph_pkg::node_idx_t next_node_idx,
    input  graph_pkg::edge_cnt_t next_node_counter,
    output graph_pkg::node_idx_t node_idx,
    output logic                 rd_next_node,
    output logic                 done,
    output logic                 load_cur,
    output logic                 add_end,
    output logic                 clear,
    queue_if.ctrl                q
);

    graph_pkg::ctrl_state_t state;
    graph_pkg::ctrl_state_t state_nxt;
    graph_pkg::node_idx_t   start_reg;
    graph_pkg::node_idx_t   end_reg;
    logic                   run_go;
    logic                   is_end;
    logic                   xfer;
    logic                   last_edge;

    // A new run only starts from a quiet sequencer
    assign run_go = start & ((state == graph_pkg::IDLE) | (state == graph_pkg::DONE));

    // Successor decode
    assign is_end    = (next_node_idx == end_reg);
    assign last_edge = (next_node_counter == graph_pkg::edge_cnt_t'(1));

    // Every edge waits for the queue to accept it
    assign xfer = (state == graph_pkg::FETCH) & rd_next_node & edge_valid & q.accept;

    // Run endpoints
    always_ff @(posedge clk) begin
        if (run_go) begin
            start_reg <= start_idx;
            end_reg   <= end_idx;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= graph_pkg::IDLE;
            node_idx     <= '0;
            rd_next_node <= 1'b0;
            done         <= 1'b0;
        end else begin
            state <= state_nxt;

            if (run_go) begin
                done <= 1'b0;
            end else if ((state == graph_pkg::POP) && q.empty) begin
                done <= 1'b1;
            end

            // Node index is held for the whole fetch of its edge list
            if ((state == graph_pkg::POP) && !q.empty) begin
                node_idx     <= q.head_idx;
                rd_next_node <= 1'b1;
            end else if (xfer && last_edge) begin
                rd_next_node <= 1'b0;
            end
        end
    end

    always_comb begin
        state_nxt   = state;
        q.seed      = 1'b0;
        q.offer     = 1'b0;
        q.pop       = 1'b0;
        q.offer_idx = next_node_idx;
        load_cur    = 1'b0;
        add_end     = 1'b0;
        clear       = 1'b0;

        case (state)
            graph_pkg::IDLE,
            graph_pkg::DONE: begin
                if (run_go) begin
                    clear     = 1'b1;
                    state_nxt = graph_pkg::SEED;
                end
            end
            graph_pkg::SEED: begin
                // Start node enters the queue with a single path
                q.seed      = 1'b1;
                q.offer_idx = start_reg;
                state_nxt   = graph_pkg::POP;
            end
            graph_pkg::POP: begin
                if (q.empty) begin
                    state_nxt = graph_pkg::DONE;
                end else begin
                    q.pop     = 1'b1;
                    load_cur  = 1'b1;
                    state_nxt = graph_pkg::FETCH;
                end
            end
            graph_pkg::FETCH: begin
                if (xfer) begin
                    if (is_end) begin
                        add_end = 1'b1;
                    end else begin
                        q.offer = 1'b1;
                    end
                    // Counter value 1 closes the node
                    if (last_edge) begin
                        state_nxt = graph_pkg::POP;
                    end
                end
            end
            default: begin
                state_nxt = graph_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: design/path_queue.sv
// Node queue with merge on match
`timescale 1ns/1ps

`include "graph_defs.svh"

module path_queue (
    input  logic  clk,
    input  logic  rst_n,
    queue_if.queue q
);

    graph_pkg::node_idx_t       idx_mem [`QUEUE_DEPTH];
    graph_pkg::count_t          val_mem [`QUEUE_DEPTH];
    logic [`QUEUE_DEPTH-1:0]    valid;

    graph_pkg::queue_ptr_t      wr_ptr;
    graph_pkg::queue_ptr_t      rd_ptr;
    graph_pkg::queue_ptr_t      hit_ptr;
    logic                       hit;
    logic                       ptr_eq;
    logic                       full;
    logic                       do_push;
    logic                       do_merge;
    logic                       do_pop;
    graph_pkg::count_t          push_val;

    // Valid slots form one contiguous run from rd_ptr, so the head slot
    // tells full from empty when the pointers meet
    assign ptr_eq  = (wr_ptr == rd_ptr);
    assign q.empty = ptr_eq & ~valid[rd_ptr];
    assign full    = ptr_eq & valid[rd_ptr];

    // Parallel lookup of the offered node against waiting entries
    always_comb begin
        hit     = 1'b0;
        hit_ptr = '0;
        for (int i = 0; i < `QUEUE_DEPTH; i++) begin
            if (valid[i] && (idx_mem[i] == q.offer_idx)) begin
                hit     = 1'b1;
                hit_ptr = graph_pkg::queue_ptr_t'(i);
            end
        end
    end

    assign q.accept = hit | ~full;

    assign q.head_idx = idx_mem[rd_ptr];
    assign q.head_val = val_mem[rd_ptr];

    // Operation decode, at most one per cycle
    assign do_merge = q.offer & hit;
    assign do_push  = q.seed | (q.offer & ~hit & ~full);
    assign do_pop   = q.pop & ~q.empty;

    // Seeded start node always carries one path
    assign push_val = q.seed ? graph_pkg::count_t'(1) : q.offer_val;

    // Slot contents
    always_ff @(posedge clk) begin
        if (do_push) begin
            idx_mem[wr_ptr] <= q.offer_idx;
            val_mem[wr_ptr] <= push_val;
        end else if (do_merge) begin
            val_mem[hit_ptr] <= val_mem[hit_ptr] + q.offer_val;
        end
    end

    // Pointers and valid flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid  <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) begin
                valid[wr_ptr] <= 1'b1;
                wr_ptr        <= wr_ptr + 1'b1;
            end else if (do_pop) begin
                // Cleared flag takes the node out of the lookup
                valid[rd_ptr] <= 1'b0;
                rd_ptr        <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

// File: design/path_accum.sv
// Current and end path counts
`timescale 1ns/1ps

module path_accum (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              load_cur,
    input  logic              add_end,
    input  logic              clear,
    output graph_pkg::count_t path_count,
    queue_if.accum            q
);

    graph_pkg::count_t cur_count;
    graph_pkg::count_t end_count;
    graph_pkg::count_t end_sum;

    // Paths into the end node grow by the count of the node being fetched
    assign end_sum = end_count + cur_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_count <= '0;
        end else if (clear) begin
            cur_count <= '0;
        end else if (load_cur) begin
            // Head count is taken as the node leaves the queue
            cur_count <= q.head_val;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_count <= '0;
        end else if (clear) begin
            end_count <= '0;
        end else if (add_end) begin
            end_count <= end_sum;
        end
    end

    // Every edge out of the current node carries its count
    assign q.offer_val = cur_count;

    assign path_count = end_count;

endmodule

// File: design/path_counter_top.sv
// Path counter top level
`timescale 1ns/1ps

module path_counter_top (
    input  logic                 clk,
    input  logic                 rst_n,

    // Run control
    input  logic                 start,
    input  graph_pkg::node_idx_t start_idx,
    input  graph_pkg::node_idx_t end_idx,

    // Edge source
    input  logic                 edge_valid,
    input  graph_pkg::node_idx_t next_node_idx,
    input  graph_pkg::edge_cnt_t next_node_counter,
    output graph_pkg::node_idx_t node_idx,
    output logic                 rd_next_node,

    // Result
    output graph_pkg::count_t    path_count,
    output logic                 done
);

    queue_if qif ();

    logic load_cur;
    logic add_end;
    logic clear;

    // Decode stage
    path_ctrl u_ctrl (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_idx         (start_idx),
        .end_idx           (end_idx),
        .edge_valid        (edge_valid),
        .next_node_idx     (next_node_idx),
        .next_node_counter (next_node_counter),
        .node_idx          (node_idx),
        .rd_next_node      (rd_next_node),
        .done              (done),
        .load_cur          (load_cur),
        .add_end           (add_end),
        .clear             (clear),
        .q                 (qif.ctrl)
    );

    // Execute stage
    path_queue u_queue (
        .clk   (clk),
        .rst_n (rst_n),
        .q     (qif.queue)
    );

    // Result stage
    path_accum u_accum (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_cur   (load_cur),
        .add_end    (add_end),
        .clear      (clear),
        .path_count (path_count),
        .q          (qif.accum)
    );

endmodule

// File: testbench/tb_graph_source.sv
// Edge source model
`timescale 1ns/1ps

module tb_graph_source (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [1:0]           graph_sel,
    input  logic                 gaps,
    input  graph_pkg::node_idx_t node_idx,
    input  logic                 rd_next_node,
    input  logic                 accept,
    output logic                 edge_valid,
    output graph_pkg::node_idx_t next_node_idx,
    output graph_pkg::edge_cnt_t next_node_counter
);

    // Four graphs of up to eight nodes, at most four edges per node
    graph_pkg::node_idx_t succ_tab [4][8][4];
    logic [2:0]           deg_tab  [4][8];

    logic [2:0] pos;
    logic [2:0] pos_next;
    logic [2:0] deg;
    logic       xfer;

    task automatic add_edge(input logic [1:0] g, input logic [2:0] n,
                            input graph_pkg::node_idx_t m);
        succ_tab[g][n][deg_tab[g][n][1:0]] = m;
        deg_tab[g][n] = deg_tab[g][n] + 3'd1;
    endtask

    initial begin
        edge_valid        = 1'b0;
        next_node_idx     = '0;
        next_node_counter = '0;
        deg_tab           = '{default: 3'd0};

        // Graph 0 is the chain 0 1 2 3
        add_edge(2'd0, 3'd0, 10'd1);
        add_edge(2'd0, 3'd1, 10'd2);
        add_edge(2'd0, 3'd2, 10'd3);

        // Graph 1 has layers {1,2} {3,4} {5,6}, fully connected, then node 7
        add_edge(2'd1, 3'd0, 10'd1);
        add_edge(2'd1, 3'd0, 10'd2);
        add_edge(2'd1, 3'd1, 10'd3);
        add_edge(2'd1, 3'd1, 10'd4);
        add_edge(2'd1, 3'd2, 10'd3);
        add_edge(2'd1, 3'd2, 10'd4);
        add_edge(2'd1, 3'd3, 10'd5);
        add_edge(2'd1, 3'd3, 10'd6);
        add_edge(2'd1, 3'd4, 10'd5);
        add_edge(2'd1, 3'd4, 10'd6);
        add_edge(2'd1, 3'd5, 10'd7);
        add_edge(2'd1, 3'd6, 10'd7);

        // Graph 2 has three parallel edges from node 0 to node 5
        add_edge(2'd2, 3'd0, 10'd5);
        add_edge(2'd2, 3'd0, 10'd5);
        add_edge(2'd2, 3'd0, 10'd5);
    end

    // Nodes outside the table have no edges
    assign deg = (node_idx < 10'd8) ? deg_tab[graph_sel][node_idx[2:0]] : 3'd0;

    // Edge taken by the DUT on this clock
    assign xfer = rd_next_node & edge_valid & accept;

    // Edge list starts over while the read request is low
    assign pos_next = !rd_next_node ? 3'd0 : (xfer ? pos + 3'd1 : pos);

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos               <= 3'd0;
            edge_valid        <= 1'b0;
            next_node_idx     <= '0;
            next_node_counter <= '0;
        end else begin
            pos <= pos_next;
            if (rd_next_node && (pos_next < deg)) begin
                next_node_idx     <= succ_tab[graph_sel][node_idx[2:0]][pos_next[1:0]];
                next_node_counter <= graph_pkg::edge_cnt_t'(deg - pos_next);
                // Roughly one cycle in four stalls when gaps are on
                edge_valid        <= gaps ? ($urandom_range(3) != 0) : 1'b1;
            end else begin
                edge_valid <= 1'b0;
            end
        end
    end

endmodule

// File: testbench/tb_path_counter.sv
// Path counter testbench
`timescale 1ns/1ps

module tb_path_counter;

    localparam int NUM_CASES       = 8;
    localparam int CYCLES_PER_CASE = 2000;

    typedef struct packed {
        logic [1:0]           graph;
        graph_pkg::node_idx_t src;
        graph_pkg::node_idx_t dst;
        logic                 gaps;
        graph_pkg::count_t    expected;
    } run_case_t;

    logic                 clk;
    logic                 rst_n;
    logic                 start;
    graph_pkg::node_idx_t start_idx;
    graph_pkg::node_idx_t end_idx;
    logic [1:0]           graph_sel;
    logic                 gaps;
    logic                 edge_valid;
    graph_pkg::node_idx_t next_node_idx;
    graph_pkg::edge_cnt_t next_node_counter;
    graph_pkg::node_idx_t node_idx;
    logic                 rd_next_node;
    graph_pkg::count_t    path_count;
    logic                 done;
    logic                 queue_accept;
    logic                 held_rd;
    graph_pkg::node_idx_t held_idx;

    run_case_t cases [NUM_CASES];
    int        errors;

    path_counter_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_idx         (start_idx),
        .end_idx           (end_idx),
        .edge_valid        (edge_valid),
        .next_node_idx     (next_node_idx),
        .next_node_counter (next_node_counter),
        .node_idx          (node_idx),
        .rd_next_node      (rd_next_node),
        .path_count        (path_count),
        .done              (done)
    );

    // Queue accept is internal to the DUT and shows the source each transfer
    assign queue_accept = dut.qif.accept;

    tb_graph_source source (
        .clk               (clk),
        .rst_n             (rst_n),
        .graph_sel         (graph_sel),
        .gaps              (gaps),
        .node_idx          (node_idx),
        .rd_next_node      (rd_next_node),
        .accept            (queue_accept),
        .edge_valid        (edge_valid),
        .next_node_idx     (next_node_idx),
        .next_node_counter (next_node_counter)
    );

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        assert (got === expected) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d",
                     $time, name, got, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Stopped at first error");
        end
    endtask

    // Node index stays put while its edge list is being read
    always @(negedge clk) begin
        if (held_rd && rd_next_node) begin
            check_value("node_idx", 32'(node_idx), 32'(held_idx));
        end
        held_rd  <= rd_next_node;
        held_idx <= node_idx;
    end

    // One run from start pulse to done and its count check
    task automatic run_graph(input run_case_t c);
        @(posedge clk);
        graph_sel <= c.graph;
        gaps      <= c.gaps;
        start_idx <= c.src;
        end_idx   <= c.dst;
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
        check_value("path_count", 32'(path_count), 32'(c.expected));
        check_value("rd_next_node", 32'(rd_next_node), 32'd0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        start     = 1'b0;
        start_idx = '0;
        end_idx   = '0;
        graph_sel = 2'd0;
        gaps      = 1'b0;
        held_rd   = 1'b0;
        held_idx  = '0;
        errors    = 0;
        void'($urandom(32'hf52d));

        // Graph, start, end, stalls, paths
        cases[0] = '{2'd0, 10'd0, 10'd3, 1'b0, 24'd1};
        cases[1] = '{2'd1, 10'd0, 10'd7, 1'b0, 24'd8};
        cases[2] = '{2'd2, 10'd0, 10'd5, 1'b0, 24'd3};
        cases[3] = '{2'd1, 10'd0, 10'd7, 1'b1, 24'd8};
        cases[4] = '{2'd2, 10'd0, 10'd5, 1'b1, 24'd3};
        cases[5] = '{2'd0, 10'd1, 10'd3, 1'b1, 24'd1};
        cases[6] = '{2'd1, 10'd3, 10'd7, 1'b0, 24'd2};
        cases[7] = '{2'd1, 10'd1, 10'd7, 1'b1, 24'd4};

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs straight after reset
        @(negedge clk);
        check_value("rd_next_node", 32'(rd_next_node), 32'd0);
        check_value("done", 32'(done), 32'd0);
        check_value("path_count", 32'(path_count), 32'd0);

        for (int i = 0; i < NUM_CASES; i++) begin
            run_graph(cases[i]);
        end

        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_CASES * CYCLES_PER_CASE) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles",
                 NUM_CASES * CYCLES_PER_CASE);
        $display("RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

endmodule

// File: src.f
+incdir+design
design/graph_pkg.sv
design/queue_if.sv
design/path_ctrl.sv
design/path_queue.sv
design/path_accum.sv
design/path_counter_top.sv
testbench/tb_graph_source.sv
testbench/tb_path_counter.sv

// File: run.sh
#!/bin/sh
# Build and run the path counter simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f src.f \
    --top-module tb_path_counter \
    -o sim_path_counter

# The verdict comes from the log, so a stopped run still leaves one
./obj_dir/sim_path_counter > sim.log 2>&1 || true
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
